// File: common/blit_cfg_pkg.sv
/* Host register map, pixel-size codes and command-word fields */

package blit_cfg_pkg;

	// Register addresses on the host bus
	localparam logic [3:0] REG_CMD    = 4'd0;
	localparam logic [3:0] REG_DST_X  = 4'd1;
	localparam logic [3:0] REG_DST_Y  = 4'd2;
	// Low half is the inner count, high half the outer count
	localparam logic [3:0] REG_COUNT  = 4'd3;
	// Read only, inner count high and outer count low
	localparam logic [3:0] REG_STATUS = 4'd4;
	// Read only, busy in bit 0
	localparam logic [3:0] REG_STATE  = 4'd5;

	// Pixel-size codes, log2 of bits per pixel
	localparam logic [2:0] PIX8  = 3'd3;
	localparam logic [2:0] PIX16 = 3'd4;
	localparam logic [2:0] PIX32 = 3'd5;

	// Command word layout
	// Pixel size sits in bits 2..0
	localparam int CMD_PIXSIZE_LSB = 0;
	// Phrase mode enable
	localparam int CMD_PHRASE_BIT  = 3;

endpackage

// File: common/blit_loop_pkg.sv
/* Loop sequencer state encoding and pixel step type */

package blit_loop_pkg;

	// Sequencer states
	// IDLE waits for a command write
	// LINE reloads the inner count or finishes the blit
	// STEP puts out one pixel run per cycle
	// LINE_END moves to the next line
	typedef enum logic [1:0] {
		IDLE     = 2'd0,
		LINE     = 2'd1,
		STEP     = 2'd2,
		LINE_END = 2'd3
	} seq_state_t;

	// Pixels covered by one step, 1 up to 8
	// Eight pixels fill a 64-bit phrase at 8 bpp
	typedef logic [3:0] step_t;

endpackage

// File: common/loop_ctrl_if.sv
/* Control link between the loop sequencer and the inner and outer counters */
`timescale 1ns/1ps

interface loop_ctrl_if #(
	parameter int ADDR_W = 16
) ();

	// Sequencer strobes
	logic ireload;
	logic icntena;
	logic odec;
	// Current destination X, low bits set the phrase step
	logic [ADDR_W-1:0] dstxp;

	// Counter status back to the sequencer
	logic inner0;
	blit_loop_pkg::step_t pix_step;
	logic outer0;

	modport seq (
		output ireload,
		output icntena,
		output odec,
		output dstxp,
		input  inner0,
		input  pix_step,
		input  outer0
	);

	modport inner (
		input  ireload,
		input  icntena,
		input  dstxp,
		output inner0,
		output pix_step
	);

	modport outer (
		input  odec,
		output outer0
	);

endinterface

// File: counters/inner_cnt.sv
/* Inner pixel counter with phrase step decode, per-line reload,
   underflow flag and status output */
`timescale 1ns/1ps

module inner_cnt #(
	parameter int CNT_W = 16
) (
	input  logic             sys_clk,
	input  logic             rst_n,
	input  logic             countld,
	input  logic [CNT_W-1:0] count_din,
	input  logic [2:0]       pixsize,
	input  logic             phrase_mode,
	loop_ctrl_if.inner       ctrl,
	output logic [CNT_W-1:0] icount,
	output logic [CNT_W-1:0] status_hi
);

	logic                 pixel8;
	logic                 pixel16;
	logic                 pixel32;
	blit_loop_pkg::step_t step;
	logic [CNT_W-1:0]     cnt_hold;
	logic [CNT_W-1:0]     count_next;
	logic                 uflow_t;
	logic                 underflow;

	// Pixel size decode
	assign pixel8  = (pixsize == blit_cfg_pkg::PIX8);
	assign pixel16 = (pixsize == blit_cfg_pkg::PIX16);
	assign pixel32 = (pixsize == blit_cfg_pkg::PIX32);

	// Step to the next phrase boundary
	// Sizes below 8 bpp fall through to a single pixel
	always_comb begin
		step = 4'd1;
		if (phrase_mode) begin
			if (pixel8) begin
				step = 4'd8 - {1'b0, ctrl.dstxp[2:0]};
			end else if (pixel16) begin
				step = 4'd4 - {2'b00, ctrl.dstxp[1:0]};
			end else if (pixel32) begin
				step = 4'd2 - {3'b000, ctrl.dstxp[0]};
			end
		end
	end

	assign ctrl.pix_step = step;

	// Count after this step
	assign count_next = icount - {{(CNT_W-4){1'b0}}, step};

	// MSB going 0 to 1 means the step ran past zero
	assign uflow_t = count_next[CNT_W-1] & ~icount[CNT_W-1];

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			cnt_hold  <= '0;
			icount    <= '0;
			underflow <= 1'b0;
		end else begin
			// Host write wins over a line reload
			if (countld) begin
				cnt_hold  <= count_din;
				icount    <= count_din;
				underflow <= 1'b0;
			end else if (ctrl.ireload) begin
				icount    <= cnt_hold;
				underflow <= 1'b0;
			end else if (ctrl.icntena) begin
				icount    <= count_next;
				underflow <= uflow_t;
			end
		end
	end

	// Line finished when the count is spent or overshot
	assign ctrl.inner0 = (icount == '0) | underflow;

	// Upper half of the status word
	assign status_hi = icount;

endmodule

// File: counters/outer_cnt.sv
/* Outer line counter with zero flag */
`timescale 1ns/1ps

module outer_cnt #(
	parameter int CNT_W = 16
) (
	input  logic             sys_clk,
	input  logic             rst_n,
	input  logic             countld,
	input  logic [CNT_W-1:0] count_din,
	loop_ctrl_if.outer       ctrl,
	output logic [CNT_W-1:0] ocount
);

	logic zero;

	assign zero = (ocount == '0);

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			ocount <= '0;
		end else begin
			// Lines left to do, loaded from the high half of COUNT
			if (countld) begin
				ocount <= count_din;
			end else if (ctrl.odec && !zero) begin
				// One line done
				ocount <= ocount - 1'b1;
			end
		end
	end

	// Sequencer checks this at every line start
	assign ctrl.outer0 = zero;

endmodule

// File: source/blit_regs.sv
/* Host register file with start and count-load strobes and read mux */
`timescale 1ns/1ps

module blit_regs #(
	parameter int ADDR_W = 16
) (
	input  logic              sys_clk,
	input  logic              rst_n,
	input  logic              reg_wr,
	input  logic              reg_rd,
	input  logic [3:0]        reg_addr,
	input  logic [31:0]       reg_wdata,
	input  logic              busy,
	input  logic [15:0]       icount,
	input  logic [15:0]       ocount,
	output logic [31:0]       reg_rdata,
	output logic              start,
	output logic              countld,
	output logic [31:0]       count_din,
	output logic [2:0]        pixsize,
	output logic              phrase_mode,
	output logic [ADDR_W-1:0] start_x,
	output logic [ADDR_W-1:0] start_y
);

	logic [3:0]  cmd_reg;
	logic [31:0] count_reg;
	logic        cmd_take;
	logic [31:0] rd_mux;

	// Command accepted only with the sequencer idle and no start in flight
	assign cmd_take = reg_wr && (reg_addr == blit_cfg_pkg::REG_CMD) && !busy && !start;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			cmd_reg   <= '0;
			count_reg <= '0;
			start_x   <= '0;
			start_y   <= '0;
			start     <= 1'b0;
			countld   <= 1'b0;
		end else begin
			// Strobes last one cycle
			start   <= cmd_take;
			countld <= reg_wr && (reg_addr == blit_cfg_pkg::REG_COUNT);
			if (cmd_take) begin
				cmd_reg <= reg_wdata[3:0];
			end
			if (reg_wr && (reg_addr == blit_cfg_pkg::REG_DST_X)) begin
				start_x <= reg_wdata[ADDR_W-1:0];
			end
			if (reg_wr && (reg_addr == blit_cfg_pkg::REG_DST_Y)) begin
				start_y <= reg_wdata[ADDR_W-1:0];
			end
			if (reg_wr && (reg_addr == blit_cfg_pkg::REG_COUNT)) begin
				count_reg <= reg_wdata;
			end
		end
	end

	// Held command fields
	assign pixsize     = cmd_reg[blit_cfg_pkg::CMD_PIXSIZE_LSB +: 3];
	assign phrase_mode = cmd_reg[blit_cfg_pkg::CMD_PHRASE_BIT];
	// Count word goes to both counters, they split it
	assign count_din   = count_reg;

	// Read data select
	always_comb begin
		case (reg_addr)
			blit_cfg_pkg::REG_CMD:    rd_mux = {28'b0, cmd_reg};
			blit_cfg_pkg::REG_DST_X:  rd_mux = 32'(start_x);
			blit_cfg_pkg::REG_DST_Y:  rd_mux = 32'(start_y);
			blit_cfg_pkg::REG_COUNT:  rd_mux = count_reg;
			blit_cfg_pkg::REG_STATUS: rd_mux = {icount, ocount};
			blit_cfg_pkg::REG_STATE:  rd_mux = {31'b0, busy};
			default:                  rd_mux = '0;
		endcase
	end

	// Bus floats to zero when not read
	assign reg_rdata = reg_rd ? rd_mux : '0;

endmodule

// File: source/loop_seq.sv
/* Line and step FSM with destination X and Y registers and pixel-run output */
`timescale 1ns/1ps

module loop_seq #(
	parameter int ADDR_W = 16
) (
	input  logic              sys_clk,
	input  logic              rst_n,
	input  logic              start,
	input  logic [ADDR_W-1:0] start_x,
	input  logic [ADDR_W-1:0] start_y,
	loop_ctrl_if.seq          ctrl,
	output logic              pix_valid,
	output logic [ADDR_W-1:0] pix_x,
	output logic [ADDR_W-1:0] pix_y,
	output logic [3:0]        pix_n,
	output logic              busy,
	output logic              done
);

	blit_loop_pkg::seq_state_t state;
	blit_loop_pkg::seq_state_t state_nxt;
	logic [ADDR_W-1:0]         dstx;
	logic [ADDR_W-1:0]         dsty;
	logic                      stepping;

	// A pixel run goes out on every STEP cycle until the line is spent
	assign stepping = (state == blit_loop_pkg::STEP) && !ctrl.inner0;

	always_comb begin
		state_nxt = state;
		case (state)
			blit_loop_pkg::IDLE:     if (start) state_nxt = blit_loop_pkg::LINE;
			// Out of lines ends the blit
			blit_loop_pkg::LINE:     state_nxt = ctrl.outer0 ? blit_loop_pkg::IDLE
				: blit_loop_pkg::STEP;
			blit_loop_pkg::STEP:     if (ctrl.inner0) state_nxt = blit_loop_pkg::LINE_END;
			blit_loop_pkg::LINE_END: state_nxt = blit_loop_pkg::LINE;
			default:                 state_nxt = blit_loop_pkg::IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state <= blit_loop_pkg::IDLE;
			dstx  <= '0;
			dsty  <= '0;
			done  <= 1'b0;
		end else begin
			state <= state_nxt;
			// Pulse in the cycle after the final LINE
			done  <= (state == blit_loop_pkg::LINE) && ctrl.outer0;
			if ((state == blit_loop_pkg::IDLE) && start) begin
				dstx <= start_x;
				dsty <= start_y;
			end else if (stepping) begin
				dstx <= dstx + ADDR_W'(ctrl.pix_step);
			end else if (state == blit_loop_pkg::LINE_END) begin
				// Back to the left edge, one line down
				dstx <= start_x;
				dsty <= dsty + 1'b1;
			end
		end
	end

	// Counter strobes
	assign ctrl.ireload = (state == blit_loop_pkg::LINE) && !ctrl.outer0;
	assign ctrl.icntena = stepping;
	assign ctrl.odec    = (state == blit_loop_pkg::LINE_END);
	assign ctrl.dstxp   = dstx;

	// Run fields straight from state and address
	assign pix_valid = stepping;
	assign pix_x     = dstx;
	assign pix_y     = dsty;
	assign pix_n     = ctrl.pix_step;
	assign busy      = (state != blit_loop_pkg::IDLE);

endmodule

// File: source/blit_loop_top.sv
/* Blitter loop control top level with host register port and pixel-run output */
`timescale 1ns/1ps

module blit_loop_top #(
	parameter int CNT_W  = 16,
	parameter int ADDR_W = 16
) (
	input  logic              sys_clk,
	input  logic              rst_n,
	input  logic              reg_wr,
	input  logic              reg_rd,
	input  logic [3:0]        reg_addr,
	input  logic [31:0]       reg_wdata,
	output logic [31:0]       reg_rdata,
	output logic              pix_valid,
	output logic [ADDR_W-1:0] pix_x,
	output logic [ADDR_W-1:0] pix_y,
	output logic [3:0]        pix_n,
	output logic              busy,
	output logic              done
);

	logic              start;
	logic              countld;
	logic [31:0]       count_din;
	logic [2:0]        pixsize;
	logic              phrase_mode;
	logic [ADDR_W-1:0] start_x;
	logic [ADDR_W-1:0] start_y;
	logic [CNT_W-1:0]  status_hi;
	logic [CNT_W-1:0]  ocount;

	loop_ctrl_if #(.ADDR_W(ADDR_W)) u_ctrl ();

	blit_regs #(.ADDR_W(ADDR_W)) u_regs (
		.sys_clk, .rst_n, .reg_wr, .reg_rd, .reg_addr, .reg_wdata,
		.busy, .icount(status_hi), .ocount,
		.reg_rdata, .start, .countld, .count_din, .pixsize, .phrase_mode,
		.start_x, .start_y
	);

	loop_seq #(.ADDR_W(ADDR_W)) u_seq (
		.sys_clk, .rst_n, .start, .start_x, .start_y, .ctrl(u_ctrl.seq),
		.pix_valid, .pix_x, .pix_y, .pix_n, .busy, .done
	);

	// Inner count from the low half of COUNT
	// Status path carries the count, so the plain count output stays open
	inner_cnt #(.CNT_W(CNT_W)) u_inner (
		.sys_clk, .rst_n, .countld, .count_din(count_din[CNT_W-1:0]),
		.pixsize, .phrase_mode, .ctrl(u_ctrl.inner), .icount(), .status_hi
	);

	// Line count from the high half
	outer_cnt #(.CNT_W(CNT_W)) u_outer (
		.sys_clk, .rst_n, .countld, .count_din(count_din[16 +: CNT_W]),
		.ctrl(u_ctrl.outer), .ocount
	);

endmodule

// File: sim/blit_loop_properties.sv
/* Concurrent assertions on the loop sequencer, bound into loop_seq */
`timescale 1ns/1ps

module blit_loop_properties #(
	parameter int ADDR_W = 16
) (
	input logic              sys_clk,
	input logic              rst_n,
	input logic              pix_valid,
	input logic [ADDR_W-1:0] pix_x,
	input logic [3:0]        pix_n,
	input logic [ADDR_W-1:0] start_x,
	input logic              done,
	input logic              ireload
);

	// Back-to-back runs on a line sit end to end
	runs_end_to_end: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(pix_valid && $past(pix_valid)) |->
		(pix_x == $past(pix_x) + ADDR_W'($past(pix_n))))
		else $error("pixel run does not start where the previous run ended");

	// Done lasts exactly one cycle
	done_one_cycle: assert property (@(posedge sys_clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done held high for more than one cycle");

	// Every line starts stepping from the start column
	reload_at_start_x: assert property (@(posedge sys_clk) disable iff (!rst_n)
		ireload |=> (pix_x == start_x))
		else $error("line does not start at the start column after a reload");

endmodule

// File: sim/blit_loop_tb.sv
/* Testbench for the blitter loop control, with run model, run monitor,
   directed tests, timeout and summary */
`timescale 1ns/1ps

module blit_loop_tb;

	// Longest blit here is about 140 cycles, all tests together stay under 1000
	localparam int CYCLE_LIMIT = 4000;

	logic        sys_clk;
	logic        rst_n;
	logic        reg_wr;
	logic        reg_rd;
	logic [3:0]  reg_addr;
	logic [31:0] reg_wdata;
	logic [31:0] reg_rdata;
	logic        pix_valid;
	logic [15:0] pix_x;
	logic [15:0] pix_y;
	logic [3:0]  pix_n;
	logic        busy;
	logic        done;

	// Expected runs as {x, y, n}
	logic [35:0] exp_q[$];
	logic [35:0] exp_run;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          done_count = 0;
	int          done_base = 0;
	int          test_num = 0;
	int          err_mark = 0;
	// Pixels of the expected runs seen so far, and those already applied to the counter
	logic [15:0] run_sum = '0;
	logic [15:0] applied_sum = '0;
	logic [31:0] rng;

	blit_loop_top #(.CNT_W(16), .ADDR_W(16)) u_dut (
		.sys_clk, .rst_n, .reg_wr, .reg_rd, .reg_addr, .reg_wdata,
		.reg_rdata, .pix_valid, .pix_x, .pix_y, .pix_n, .busy, .done
	);

	bind loop_seq blit_loop_properties #(.ADDR_W(ADDR_W)) u_props (
		.sys_clk, .rst_n, .pix_valid, .pix_x, .pix_n, .start_x, .done,
		.ireload(ctrl.ireload)
	);

	always #20 sys_clk = ~sys_clk;

	// Hang guard
	always @(posedge sys_clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: blit did not finish");
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Counter has taken every run from the cycles before this edge
	always @(posedge sys_clk) begin
		applied_sum = run_sum;
	end

	// Outputs settle after the rising edge, so look at them on the falling one
	always @(negedge sys_clk) begin
		if (rst_n) begin
			if (pix_valid) begin
				if (exp_q.size() == 0) begin
					$display("ERROR at %0t: pixel run seen when none was expected", $time);
					errors++;
				end else begin
					exp_run = exp_q.pop_front();
					check_eq(32'(pix_x), 32'(exp_run[35:20]), "pix_x");
					check_eq(32'(pix_y), 32'(exp_run[19:4]), "pix_y");
					check_eq(32'(pix_n), 32'(exp_run[3:0]), "pix_n");
					run_sum = run_sum + 16'(exp_run[3:0]);
				end
			end
			if (done) begin
				done_count++;
			end
		end
	end

	// Pixels to the next phrase boundary, one pixel when not in phrase mode
	function automatic logic [3:0] phrase_step(input logic [15:0] x, input logic [2:0] psize,
		input logic phrase);
		if (!phrase) begin
			return 4'd1;
		end
		case (psize)
			blit_cfg_pkg::PIX8:  return 4'(8 - (x % 8));
			blit_cfg_pkg::PIX16: return 4'(4 - (x % 4));
			blit_cfg_pkg::PIX32: return 4'(2 - (x % 2));
			default:             return 4'd1;
		endcase
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Queue every run of a blit, line by line
	task automatic predict_blit(input logic [15:0] sx, input logic [15:0] sy,
		input logic [15:0] c, input logic [15:0] o, input logic [2:0] psize, input logic phrase);
		logic [15:0] x;
		logic [15:0] cnt;
		logic [15:0] nxt;
		logic        uf;
		logic [3:0]  st;
		int          line;
		for (line = 0; line < int'(o); line++) begin
			x = sx;
			cnt = c;
			uf = 1'b0;
			// Line ends on zero or on a step that wraps past zero
			while (cnt != 16'd0 && !uf) begin
				st = phrase_step(x, psize, phrase);
				exp_q.push_back({x, sy + 16'(line), st});
				nxt = cnt - 16'(st);
				uf = nxt[15] && !cnt[15];
				cnt = nxt;
				x = x + 16'(st);
			end
		end
	endtask

	task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
		reg_wr = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(negedge sys_clk);
		reg_wr = 1'b0;
	endtask

	// Read data is combinational, taken just after the address is set
	task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
		reg_rd = 1'b1;
		reg_addr = addr;
		#1;
		data = reg_rdata;
		@(negedge sys_clk);
		reg_rd = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge sys_clk);
	endtask

	task automatic launch_blit(input logic [15:0] sx, input logic [15:0] sy,
		input logic [15:0] c, input logic [15:0] o, input logic [2:0] psize, input logic phrase);
		reg_write(blit_cfg_pkg::REG_DST_X, 32'(sx));
		reg_write(blit_cfg_pkg::REG_DST_Y, 32'(sy));
		reg_write(blit_cfg_pkg::REG_COUNT, {o, c});
		predict_blit(sx, sy, c, o, psize, phrase);
		run_sum = '0;
		done_base = done_count;
		reg_write(blit_cfg_pkg::REG_CMD, {28'b0, phrase, psize});
	endtask

	// Wait for done, then make sure it came once and every run was seen
	task automatic await_blit();
		while (done_count == done_base) begin
			@(negedge sys_clk);
		end
		idle_cycles(3);
		check_eq(32'(done_count - done_base), 32'd1, "done pulses");
		check_eq(32'(exp_q.size()), 32'd0, "runs still expected");
		check_eq(32'(busy), 32'd0, "busy after done");
	endtask

	task automatic report_test(input string name);
		test_num++;
		$display("test %0d %s: %s", test_num, name, (errors == err_mark) ? "ok" : "errors");
		err_mark = errors;
	endtask

	task automatic check_reset_state();
		logic [31:0] rd;
		check_eq(32'(busy), 32'd0, "busy after reset");
		check_eq(32'(pix_valid), 32'd0, "pix_valid after reset");
		check_eq(32'(done), 32'd0, "done after reset");
		reg_read(blit_cfg_pkg::REG_STATUS, rd);
		check_eq(rd, 32'd0, "status after reset");
		report_test("reset state");
	endtask

	task automatic run_pixel_lines();
		launch_blit(16'd5, 16'd10, 16'd7, 16'd3, blit_cfg_pkg::PIX16, 1'b0);
		await_blit();
		report_test("pixel mode lines");
	endtask

	// Unaligned starts, last run of each line overshoots the count
	task automatic run_phrase_steps();
		launch_blit(16'd3, 16'd0, 16'd14, 16'd2, blit_cfg_pkg::PIX8, 1'b1);
		await_blit();
		launch_blit(16'd6, 16'd4, 16'd9, 16'd2, blit_cfg_pkg::PIX16, 1'b1);
		await_blit();
		launch_blit(16'd7, 16'd8, 16'd6, 16'd2, blit_cfg_pkg::PIX32, 1'b1);
		await_blit();
		report_test("phrase mode steps");
	endtask

	task automatic read_status_counts();
		logic [31:0] rd;
		logic [15:0] exp16;
		reg_write(blit_cfg_pkg::REG_COUNT, {16'd3, 16'd20});
		// Count load lands one edge after the write strobe
		idle_cycles(1);
		reg_read(blit_cfg_pkg::REG_STATUS, rd);
		check_eq(rd, {16'd20, 16'd3}, "status after count load");
		launch_blit(16'd0, 16'd2, 16'd20, 16'd1, blit_cfg_pkg::PIX16, 1'b0);
		idle_cycles(4);
		repeat (3) begin
			// Count in this cycle reflects every earlier run
			exp16 = 16'd20 - applied_sum;
			reg_read(blit_cfg_pkg::REG_STATUS, rd);
			check_eq(32'(rd[31:16]), 32'(exp16), "inner count mid blit");
		end
		await_blit();
		report_test("status reads");
	endtask

	task automatic busy_cmd_and_random();
		logic [31:0] rd;
		logic [2:0]  psize;
		int          i;
		launch_blit(16'd1, 16'd3, 16'd6, 16'd2, blit_cfg_pkg::PIX16, 1'b0);
		idle_cycles(1);
		check_eq(32'(busy), 32'd1, "busy before second command");
		// Second command while busy must change nothing
		reg_write(blit_cfg_pkg::REG_CMD, {28'b0, 1'b1, blit_cfg_pkg::PIX32});
		reg_read(blit_cfg_pkg::REG_CMD, rd);
		check_eq(rd, {28'b0, 1'b0, blit_cfg_pkg::PIX16}, "command after busy write");
		await_blit();
		for (i = 0; i < 5; i++) begin
			rng = lcg_next(rng);
			psize = (rng[13:12] == 2'd0) ? blit_cfg_pkg::PIX8
				: (rng[13:12] == 2'd1) ? blit_cfg_pkg::PIX16 : blit_cfg_pkg::PIX32;
			launch_blit(16'(rng[27:24]), 16'(rng[23:20]), 16'(rng[20:16]),
				16'(rng[9:8]) + 16'd1, psize, rng[31]);
			await_blit();
		end
		report_test("busy command and random blits");
	endtask

	task automatic run_empty_counts();
		// No lines at all
		launch_blit(16'd2, 16'd0, 16'd5, 16'd0, blit_cfg_pkg::PIX8, 1'b1);
		await_blit();
		// Lines with nothing in them
		launch_blit(16'd2, 16'd0, 16'd0, 16'd2, blit_cfg_pkg::PIX8, 1'b0);
		await_blit();
		report_test("empty counts");
	endtask

	initial begin
		sys_clk = 1'b0;
		rst_n = 1'b0;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		rng = 32'hb194_7a6c;
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n = 1'b1;
		@(negedge sys_clk);
		check_reset_state();
		run_pixel_lines();
		run_phrase_steps();
		read_status_counts();
		busy_cmd_and_random();
		run_empty_counts();
		$display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: blit_loop_top.f
common/blit_cfg_pkg.sv
common/blit_loop_pkg.sv
common/loop_ctrl_if.sv
counters/inner_cnt.sv
counters/outer_cnt.sv
source/blit_regs.sv
source/loop_seq.sv
source/blit_loop_top.sv
sim/blit_loop_properties.sv
sim/blit_loop_tb.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= blit_loop_tb
RTL_TOP   ?= blit_loop_top
FILELIST  ?= blit_loop_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
